//--- dsp_top.f
+incdir+verif
hw/dsp_pkg.sv
hw/pulse_cmd_if.sv
hw/seq_fsm.sv
hw/acq_addr_counter.sv
hw/cmd_dispatch.sv
hw/elem_cmd_reg.sv
hw/acq_capture.sv
hw/dsp_top.sv
verif/tb_dsp_top.sv

//--- hw/acq_addr_counter.sv
`default_nettype none

module acq_addr_counter (
	input  logic dspif,
	input  logic rst_n,
	input  logic clear,
	input  logic advance,
	output logic [dsp_pkg::acq_addr_width-1:0] addr,
	output logic last
);

	assign last = &addr;

	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			addr <= '0;
		end else if (clear) begin
			addr <= '0;
		end else if (advance && !last) begin
			addr <= addr + 1'b1; // locks at last address.
		end
	end

	// buffer must never wrap and overwrite captured data.
	assert property (@(posedge dspif) disable iff (!rst_n)
		last && !clear |=> addr != '0)
		else $error("acq_addr_counter: address wrapped without clear");

endmodule

`default_nettype wire

//--- hw/acq_capture.sv
`default_nettype none

module acq_capture (
	input  logic dspif,
	input  logic rst_n,
	input  logic run,
	input  logic [dsp_pkg::acq_addr_width-1:0] addr,
	input  logic last,
	input  logic [dsp_pkg::adc_width-1:0] adc,
	output logic acq_we,
	output logic [dsp_pkg::acq_addr_width-1:0] acq_addr,
	output logic [dsp_pkg::adc_width-1:0] acq_data
);

	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			acq_we <= 1'b0;
		end else begin
			acq_we <= run && !last; // no write at locked address.
		end
	end

	// data and address aligned with the write enable.
	always_ff @(posedge dspif) begin
		acq_addr <= addr;
		acq_data <= adc;
	end

endmodule

`default_nettype wire

//--- hw/cmd_dispatch.sv
`default_nettype none

module cmd_dispatch (
	input  logic dspif,
	input  logic rst_n,
	input  logic run,
	input  logic cmd_valid,
	input  logic [dsp_pkg::env_width-1:0] cmd_env_word,
	input  logic [dsp_pkg::amp_width-1:0] cmd_amp,
	input  logic [dsp_pkg::freq_width-1:0] cmd_freq,
	input  logic [dsp_pkg::phase_width-1:0] cmd_phase,
	input  logic [dsp_pkg::cfg_width-1:0] cmd_cfg,
	output logic cmd_ready,
	pulse_cmd_if.disp qdrv,
	pulse_cmd_if.disp rdrv,
	pulse_cmd_if.disp rdlo
);

	dsp_pkg::elem_sel_e sel;
	logic accept;
	logic [2:0] sel_hot;
	logic [2:0] stb_q;
	logic [dsp_pkg::env_width-1:0] env_q;
	logic [dsp_pkg::amp_width-1:0] amp_q;
	logic [dsp_pkg::freq_width-1:0] freq_q;
	logic [dsp_pkg::phase_width-1:0] phase_q;
	logic [dsp_pkg::cfg_width-3:0] mode_q;

	assign cmd_ready = run;
	assign accept = cmd_valid && cmd_ready;
	assign sel = dsp_pkg::elem_sel_e'(cmd_cfg[1:0]);

	always_comb begin
		case (sel)
			dsp_pkg::ELEM_QDRV: sel_hot = 3'b001;
			dsp_pkg::ELEM_RDRV: sel_hot = 3'b010;
			dsp_pkg::ELEM_RDLO: sel_hot = 3'b100;
			dsp_pkg::ELEM_NONE: sel_hot = 3'b000; // accepted, dropped.
			default: sel_hot = 3'b000;
		endcase
	end

	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			stb_q <= 3'b000;
		end else begin
			stb_q <= accept ? sel_hot : 3'b000;
		end
	end

	always_ff @(posedge dspif) begin
		if (accept) begin
			env_q <= cmd_env_word;
			amp_q <= cmd_amp;
			freq_q <= cmd_freq;
			phase_q <= cmd_phase;
			mode_q <= cmd_cfg[dsp_pkg::cfg_width-1:2];
		end
	end

	assign qdrv.stb = stb_q[0];
	assign rdrv.stb = stb_q[1];
	assign rdlo.stb = stb_q[2];

	// fields shared, strobe picks the element.
	assign qdrv.env_word = env_q;
	assign qdrv.amp = amp_q;
	assign qdrv.freq = freq_q;
	assign qdrv.phase = phase_q;
	assign qdrv.mode = mode_q;
	assign rdrv.env_word = env_q;
	assign rdrv.amp = amp_q;
	assign rdrv.freq = freq_q;
	assign rdrv.phase = phase_q;
	assign rdrv.mode = mode_q;
	assign rdlo.env_word = env_q;
	assign rdlo.amp = amp_q;
	assign rdlo.freq = freq_q;
	assign rdlo.phase = phase_q;
	assign rdlo.mode = mode_q;

	assert property (@(posedge dspif) disable iff (!rst_n)
		$onehot0({qdrv.stb, rdrv.stb, rdlo.stb}))
		else $error("cmd_dispatch: command routed to more than one element");

endmodule

`default_nettype wire

//--- hw/dsp_pkg.sv
`default_nettype none

package dsp_pkg;

	localparam int env_width = 24;
	localparam int phase_width = 17;
	localparam int freq_width = 9;
	localparam int amp_width = 16;
	localparam int cfg_width = 4;

	localparam int env_len_lsb = 12; // length field inside envelope word.
	localparam int qdrv_env_field = 10;
	localparam int rd_env_field = 12;

	localparam int adc_width = 64;
	localparam int acq_addr_width = 13; // last address is all ones.

	localparam int flush_cycles = 2;

	// element select, low two cfg bits.
	typedef enum logic [1:0] {
		ELEM_QDRV = 2'd0,
		ELEM_RDRV = 2'd1,
		ELEM_RDLO = 2'd2,
		ELEM_NONE = 2'd3
	} elem_sel_e;

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_FLUSH,
		SEQ_RUN
	} seq_state_e;

endpackage

`default_nettype wire

//--- hw/dsp_top.sv
`default_nettype none

module dsp_top (
	input  logic dspif,
	input  logic rst_n,
	input  logic start,
	input  logic cmd_valid,
	input  logic [dsp_pkg::env_width-1:0] cmd_env_word,
	input  logic [dsp_pkg::amp_width-1:0] cmd_amp,
	input  logic [dsp_pkg::freq_width-1:0] cmd_freq,
	input  logic [dsp_pkg::phase_width-1:0] cmd_phase,
	input  logic [dsp_pkg::cfg_width-1:0] cmd_cfg,
	input  logic [dsp_pkg::adc_width-1:0] adc,
	output logic cmd_ready,
	output logic qdrv_stb,
	output logic [dsp_pkg::qdrv_env_field-1:0] qdrv_env_start,
	output logic [dsp_pkg::qdrv_env_field-1:0] qdrv_env_length,
	output logic [dsp_pkg::amp_width-1:0] qdrv_amp,
	output logic [dsp_pkg::freq_width-1:0] qdrv_freq,
	output logic [dsp_pkg::phase_width-1:0] qdrv_phase,
	output logic [dsp_pkg::cfg_width-3:0] qdrv_mode,
	output logic rdrv_stb,
	output logic [dsp_pkg::rd_env_field-1:0] rdrv_env_start,
	output logic [dsp_pkg::rd_env_field-1:0] rdrv_env_length,
	output logic [dsp_pkg::amp_width-1:0] rdrv_amp,
	output logic [dsp_pkg::freq_width-1:0] rdrv_freq,
	output logic [dsp_pkg::phase_width-1:0] rdrv_phase,
	output logic [dsp_pkg::cfg_width-3:0] rdrv_mode,
	output logic rdlo_stb,
	output logic [dsp_pkg::rd_env_field-1:0] rdlo_env_start,
	output logic [dsp_pkg::rd_env_field-1:0] rdlo_env_length,
	output logic [dsp_pkg::amp_width-1:0] rdlo_amp,
	output logic [dsp_pkg::freq_width-1:0] rdlo_freq,
	output logic [dsp_pkg::phase_width-1:0] rdlo_phase,
	output logic [dsp_pkg::cfg_width-3:0] rdlo_mode,
	output logic acq_we,
	output logic [dsp_pkg::acq_addr_width-1:0] acq_addr,
	output logic [dsp_pkg::adc_width-1:0] acq_data
);

	logic run;
	logic elem_clear;
	logic acq_clear;
	logic acq_run;
	logic [dsp_pkg::acq_addr_width-1:0] cnt_addr;
	logic cnt_last;

	pulse_cmd_if qdrv_cmd ();
	pulse_cmd_if rdrv_cmd ();
	pulse_cmd_if rdlo_cmd ();

	seq_fsm i_seq_fsm (
		.dspif(dspif),
		.rst_n(rst_n),
		.start(start),
		.run(run),
		.elem_clear(elem_clear),
		.acq_clear(acq_clear),
		.acq_run(acq_run)
	);

	cmd_dispatch i_cmd_dispatch (
		.dspif(dspif),
		.rst_n(rst_n),
		.run(run),
		.cmd_valid(cmd_valid),
		.cmd_env_word(cmd_env_word),
		.cmd_amp(cmd_amp),
		.cmd_freq(cmd_freq),
		.cmd_phase(cmd_phase),
		.cmd_cfg(cmd_cfg),
		.cmd_ready(cmd_ready),
		.qdrv(qdrv_cmd.disp),
		.rdrv(rdrv_cmd.disp),
		.rdlo(rdlo_cmd.disp)
	);

	elem_cmd_reg #(
		.env_field(dsp_pkg::qdrv_env_field)
	) i_qdrv_reg (
		.dspif(dspif),
		.rst_n(rst_n),
		.clear(elem_clear),
		.cmd(qdrv_cmd.elem),
		.stb(qdrv_stb),
		.env_start(qdrv_env_start),
		.env_length(qdrv_env_length),
		.amp(qdrv_amp),
		.freq(qdrv_freq),
		.phase(qdrv_phase),
		.mode(qdrv_mode)
	);

	elem_cmd_reg #(
		.env_field(dsp_pkg::rd_env_field)
	) i_rdrv_reg (
		.dspif(dspif),
		.rst_n(rst_n),
		.clear(elem_clear),
		.cmd(rdrv_cmd.elem),
		.stb(rdrv_stb),
		.env_start(rdrv_env_start),
		.env_length(rdrv_env_length),
		.amp(rdrv_amp),
		.freq(rdrv_freq),
		.phase(rdrv_phase),
		.mode(rdrv_mode)
	);

	elem_cmd_reg #(
		.env_field(dsp_pkg::rd_env_field)
	) i_rdlo_reg (
		.dspif(dspif),
		.rst_n(rst_n),
		.clear(elem_clear),
		.cmd(rdlo_cmd.elem),
		.stb(rdlo_stb),
		.env_start(rdlo_env_start),
		.env_length(rdlo_env_length),
		.amp(rdlo_amp),
		.freq(rdlo_freq),
		.phase(rdlo_phase),
		.mode(rdlo_mode)
	);

	acq_addr_counter i_acq_addr_counter (
		.dspif(dspif),
		.rst_n(rst_n),
		.clear(acq_clear),
		.advance(acq_run),
		.addr(cnt_addr),
		.last(cnt_last)
	);

	acq_capture i_acq_capture (
		.dspif(dspif),
		.rst_n(rst_n),
		.run(acq_run),
		.addr(cnt_addr),
		.last(cnt_last),
		.adc(adc),
		.acq_we(acq_we),
		.acq_addr(acq_addr),
		.acq_data(acq_data)
	);

endmodule

`default_nettype wire

//--- hw/elem_cmd_reg.sv
`default_nettype none

module elem_cmd_reg #(
	parameter int env_field = dsp_pkg::rd_env_field
) (
	input  logic dspif,
	input  logic rst_n,
	input  logic clear,
	pulse_cmd_if.elem cmd,
	output logic stb,
	output logic [env_field-1:0] env_start,
	output logic [env_field-1:0] env_length,
	output logic [dsp_pkg::amp_width-1:0] amp,
	output logic [dsp_pkg::freq_width-1:0] freq,
	output logic [dsp_pkg::phase_width-1:0] phase,
	output logic [dsp_pkg::cfg_width-3:0] mode
);

	always_ff @(posedge dspif) begin
		if (!rst_n || clear) begin
			stb <= 1'b0;
			env_start <= '0;
			env_length <= '0;
			amp <= '0;
			freq <= '0;
			phase <= '0;
			mode <= '0;
		end else begin
			stb <= cmd.stb;
			if (cmd.stb) begin
				env_start <= cmd.env_word[env_field-1:0];
				env_length <= cmd.env_word[dsp_pkg::env_len_lsb +: env_field];
				amp <= cmd.amp;
				freq <= cmd.freq;
				phase <= cmd.phase;
				mode <= cmd.mode;
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/pulse_cmd_if.sv
`default_nettype none

interface pulse_cmd_if;

	logic stb; // one cycle per command.
	logic [dsp_pkg::env_width-1:0] env_word;
	logic [dsp_pkg::amp_width-1:0] amp;
	logic [dsp_pkg::freq_width-1:0] freq;
	logic [dsp_pkg::phase_width-1:0] phase;
	logic [dsp_pkg::cfg_width-3:0] mode;

	modport disp (
		output stb, env_word, amp, freq, phase, mode
	);

	modport elem (
		input stb, env_word, amp, freq, phase, mode
	);

endinterface

`default_nettype wire

//--- hw/seq_fsm.sv
`default_nettype none

module seq_fsm (
	input  logic dspif,
	input  logic rst_n,
	input  logic start,
	output logic run,
	output logic elem_clear,
	output logic acq_clear,
	output logic acq_run
);

	dsp_pkg::seq_state_e state;
	logic [$clog2(dsp_pkg::flush_cycles + 1)-1:0] flush_cnt;

	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			state <= dsp_pkg::SEQ_IDLE;
			flush_cnt <= '0;
		end else if (start) begin
			state <= dsp_pkg::SEQ_FLUSH; // restart from any state.
			flush_cnt <= '0;
		end else begin
			case (state)
				dsp_pkg::SEQ_FLUSH: begin
					if (int'(flush_cnt) == dsp_pkg::flush_cycles - 1) begin
						state <= dsp_pkg::SEQ_RUN;
					end else begin
						flush_cnt <= flush_cnt + 1'b1;
					end
				end
				dsp_pkg::SEQ_RUN: begin
					state <= dsp_pkg::SEQ_RUN;
				end
				default: begin
					state <= dsp_pkg::SEQ_IDLE; // wait for first start.
				end
			endcase
		end
	end

	assign run = (state == dsp_pkg::SEQ_RUN);
	assign acq_run = (state == dsp_pkg::SEQ_RUN);
	assign elem_clear = (state == dsp_pkg::SEQ_FLUSH);
	assign acq_clear = (state == dsp_pkg::SEQ_FLUSH);

	// pulse path stays closed for the whole flush window.
	assert property (@(posedge dspif) disable iff (!rst_n)
		start |=> !run ##1 !run)
		else $error("seq_fsm: run raised inside flush window");

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# compile with Verilator, run, and look for the pass line in the output
verilator --binary --timing -Wno-fatal --top-module tb_dsp_top -f dsp_top.f -o sim_dsp_top \
	&& ./obj_dir/sim_dsp_top | tee /dev/stderr | grep -q "Done: no errors" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

//--- verif/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

localparam int acq_last = (1 << dsp_pkg::acq_addr_width) - 1;

int m_flush_left;
logic m_run;
int m_cnt;
logic m_we;
int m_acq_addr;
logic [dsp_pkg::adc_width-1:0] m_acq_data;
int m_p_sel; // -1 when nothing in flight.
logic [dsp_pkg::env_width-1:0] m_p_env;
logic [dsp_pkg::amp_width-1:0] m_p_amp;
logic [dsp_pkg::freq_width-1:0] m_p_freq;
logic [dsp_pkg::phase_width-1:0] m_p_phase;
logic [1:0] m_p_mode;
logic m_stb [3];
logic [dsp_pkg::rd_env_field-1:0] m_start [3];
logic [dsp_pkg::rd_env_field-1:0] m_len [3];
logic [dsp_pkg::amp_width-1:0] m_amp [3];
logic [dsp_pkg::freq_width-1:0] m_freq [3];
logic [dsp_pkg::phase_width-1:0] m_phase [3];
logic [1:0] m_mode [3];

function automatic logic [31:0] next_rand();
	seed = seed * 32'd1664525 + 32'd1013904223;
	return seed;
endfunction

task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
	if (got !== exp) begin
		errors++;
		$display("FAIL %s: got %h, expected %h", name, got, exp);
	end
endtask

task automatic clear_elem(input int e);
	m_stb[e] = 1'b0;
	m_start[e] = '0;
	m_len[e] = '0;
	m_amp[e] = '0;
	m_freq[e] = '0;
	m_phase[e] = '0;
	m_mode[e] = '0;
endtask

task automatic model_reset();
	int e;
	m_flush_left = 0;
	m_run = 1'b0;
	m_cnt = 0;
	m_we = 1'b0;
	m_p_sel = -1;
	for (e = 0; e < 3; e++) begin
		clear_elem(e);
	end
endtask

// one clock edge, later stages first so each reads the old state.
task automatic model_step();
	int e;
	int w;
	logic flushing;
	logic [dsp_pkg::env_width-1:0] mask;
	logic [dsp_pkg::env_width-1:0] tmp_start;
	logic [dsp_pkg::env_width-1:0] tmp_len;
	flushing = (m_flush_left > 0);
	for (e = 0; e < 3; e++) begin
		w = (e == 0) ? dsp_pkg::qdrv_env_field : dsp_pkg::rd_env_field;
		mask = {dsp_pkg::env_width{1'b1}} >> (dsp_pkg::env_width - w);
		if (flushing) begin
			clear_elem(e);
		end else begin
			m_stb[e] = (m_p_sel == e);
			if (m_p_sel == e) begin
				tmp_start = m_p_env & mask;
				tmp_len = (m_p_env >> dsp_pkg::env_len_lsb) & mask;
				m_start[e] = tmp_start[dsp_pkg::rd_env_field-1:0];
				m_len[e] = tmp_len[dsp_pkg::rd_env_field-1:0];
				m_amp[e] = m_p_amp;
				m_freq[e] = m_p_freq;
				m_phase[e] = m_p_phase;
				m_mode[e] = m_p_mode;
			end
		end
	end
	m_p_sel = -1;
	if (cmd_valid && m_run && cmd_cfg[1:0] != 2'd3) begin
		m_p_sel = int'(cmd_cfg[1:0]);
		m_p_env = cmd_env_word;
		m_p_amp = cmd_amp;
		m_p_freq = cmd_freq;
		m_p_phase = cmd_phase;
		m_p_mode = cmd_cfg[3:2];
	end
	m_we = m_run && (m_cnt != acq_last);
	m_acq_addr = m_cnt;
	m_acq_data = adc;
	if (flushing) begin
		m_cnt = 0;
	end else if (m_run && m_cnt != acq_last) begin
		m_cnt++;
	end
	if (start) begin
		m_flush_left = dsp_pkg::flush_cycles;
		m_run = 1'b0;
	end else if (m_flush_left > 0) begin
		m_flush_left--;
		m_run = (m_flush_left == 0);
	end
endtask

`endif

//--- verif/tb_dsp_top.sv
`default_nettype none

module tb_dsp_top;

	logic dspif;
	logic rst_n;
	logic start;
	logic cmd_valid;
	logic [dsp_pkg::env_width-1:0] cmd_env_word;
	logic [dsp_pkg::amp_width-1:0] cmd_amp;
	logic [dsp_pkg::freq_width-1:0] cmd_freq;
	logic [dsp_pkg::phase_width-1:0] cmd_phase;
	logic [dsp_pkg::cfg_width-1:0] cmd_cfg;
	logic [dsp_pkg::adc_width-1:0] adc;
	logic cmd_ready;
	logic qdrv_stb;
	logic [dsp_pkg::qdrv_env_field-1:0] qdrv_env_start;
	logic [dsp_pkg::qdrv_env_field-1:0] qdrv_env_length;
	logic [dsp_pkg::amp_width-1:0] qdrv_amp;
	logic [dsp_pkg::freq_width-1:0] qdrv_freq;
	logic [dsp_pkg::phase_width-1:0] qdrv_phase;
	logic [1:0] qdrv_mode;
	logic rdrv_stb;
	logic [dsp_pkg::rd_env_field-1:0] rdrv_env_start;
	logic [dsp_pkg::rd_env_field-1:0] rdrv_env_length;
	logic [dsp_pkg::amp_width-1:0] rdrv_amp;
	logic [dsp_pkg::freq_width-1:0] rdrv_freq;
	logic [dsp_pkg::phase_width-1:0] rdrv_phase;
	logic [1:0] rdrv_mode;
	logic rdlo_stb;
	logic [dsp_pkg::rd_env_field-1:0] rdlo_env_start;
	logic [dsp_pkg::rd_env_field-1:0] rdlo_env_length;
	logic [dsp_pkg::amp_width-1:0] rdlo_amp;
	logic [dsp_pkg::freq_width-1:0] rdlo_freq;
	logic [dsp_pkg::phase_width-1:0] rdlo_phase;
	logic [1:0] rdlo_mode;
	logic acq_we;
	logic [dsp_pkg::acq_addr_width-1:0] acq_addr;
	logic [dsp_pkg::adc_width-1:0] acq_data;
	int errors;
	logic checking;
	logic [31:0] seed;

	`include "tb_model.svh"

	dsp_top i_dsp_top (
		.dspif(dspif),
		.rst_n(rst_n),
		.start(start),
		.cmd_valid(cmd_valid),
		.cmd_env_word(cmd_env_word),
		.cmd_amp(cmd_amp),
		.cmd_freq(cmd_freq),
		.cmd_phase(cmd_phase),
		.cmd_cfg(cmd_cfg),
		.adc(adc),
		.cmd_ready(cmd_ready),
		.qdrv_stb(qdrv_stb),
		.qdrv_env_start(qdrv_env_start),
		.qdrv_env_length(qdrv_env_length),
		.qdrv_amp(qdrv_amp),
		.qdrv_freq(qdrv_freq),
		.qdrv_phase(qdrv_phase),
		.qdrv_mode(qdrv_mode),
		.rdrv_stb(rdrv_stb),
		.rdrv_env_start(rdrv_env_start),
		.rdrv_env_length(rdrv_env_length),
		.rdrv_amp(rdrv_amp),
		.rdrv_freq(rdrv_freq),
		.rdrv_phase(rdrv_phase),
		.rdrv_mode(rdrv_mode),
		.rdlo_stb(rdlo_stb),
		.rdlo_env_start(rdlo_env_start),
		.rdlo_env_length(rdlo_env_length),
		.rdlo_amp(rdlo_amp),
		.rdlo_freq(rdlo_freq),
		.rdlo_phase(rdlo_phase),
		.rdlo_mode(rdlo_mode),
		.acq_we(acq_we),
		.acq_addr(acq_addr),
		.acq_data(acq_data)
	);

	always #5 dspif = ~dspif;

	always @(posedge dspif) begin
		if (!rst_n) begin
			model_reset();
		end else begin
			model_step();
		end
	end

	always @(posedge dspif) begin
		#1;
		adc = {next_rand(), next_rand()}; // new sample every cycle.
	end

	task automatic compare_elem(input string pfx, input int e, input logic stb,
			input logic [11:0] s, input logic [11:0] l, input logic [15:0] a,
			input logic [8:0] f, input logic [16:0] p, input logic [1:0] m);
		check_value({pfx, "_stb"}, stb, m_stb[e]);
		check_value({pfx, "_env_start"}, s, m_start[e]);
		check_value({pfx, "_env_length"}, l, m_len[e]);
		check_value({pfx, "_amp"}, a, m_amp[e]);
		check_value({pfx, "_freq"}, f, m_freq[e]);
		check_value({pfx, "_phase"}, p, m_phase[e]);
		check_value({pfx, "_mode"}, m, m_mode[e]);
	endtask

	always @(negedge dspif) begin
		if (checking) begin
			check_value("cmd_ready", cmd_ready, m_run);
			check_value("acq_we", acq_we, m_we);
			if (m_we) begin
				check_value("acq_addr", acq_addr, m_acq_addr);
				check_value("acq_data", acq_data, m_acq_data);
			end
			compare_elem("qdrv", 0, qdrv_stb, qdrv_env_start, qdrv_env_length, qdrv_amp,
				qdrv_freq, qdrv_phase, qdrv_mode);
			compare_elem("rdrv", 1, rdrv_stb, rdrv_env_start, rdrv_env_length, rdrv_amp,
				rdrv_freq, rdrv_phase, rdrv_mode);
			compare_elem("rdlo", 2, rdlo_stb, rdlo_env_start, rdlo_env_length, rdlo_amp,
				rdlo_freq, rdlo_phase, rdlo_mode);
		end
	end

	task automatic next_cycle();
		@(posedge dspif);
		#1;
	endtask

	task automatic pulse_start();
		start = 1'b1;
		next_cycle();
		start = 1'b0;
	endtask

	// holds valid until the DUT takes the command.
	task automatic send_cmd(input logic [3:0] cfg);
		int n;
		logic accepted;
		accepted = 1'b0;
		cmd_valid = 1'b1;
		cmd_cfg = cfg;
		cmd_env_word = 24'(next_rand());
		cmd_amp = 16'(next_rand());
		cmd_freq = 9'(next_rand());
		cmd_phase = 17'(next_rand());
		for (n = 0; n < 50 && !accepted; n++) begin
			@(negedge dspif);
			accepted = cmd_ready;
			next_cycle();
		end
		cmd_valid = 1'b0;
		if (!accepted) begin
			errors++;
			$display("timeout: command was never accepted");
		end
	endtask

	// counts low cycles of cmd_ready, returns at the negedge where it is high.
	task automatic wait_ready(output int lows);
		int n;
		logic seen;
		lows = 0;
		seen = 1'b0;
		for (n = 0; n < 20 && !seen; n++) begin
			@(negedge dspif);
			seen = cmd_ready;
			if (!seen) begin
				lows++;
			end
		end
		if (!seen) begin
			errors++;
			$display("timeout: cmd_ready did not rise after start");
		end
	endtask

	task automatic wait_write(output logic [dsp_pkg::acq_addr_width-1:0] first_addr);
		int n;
		logic seen;
		seen = 1'b0;
		first_addr = '1;
		for (n = 0; n < 20 && !seen; n++) begin
			@(negedge dspif);
			seen = acq_we;
			first_addr = acq_addr;
		end
		if (!seen) begin
			errors++;
			$display("timeout: acquisition never started writing");
		end
	endtask

	task automatic wait_lock();
		int n;
		logic locked;
		locked = 1'b0;
		for (n = 0; n < 9000 && !locked; n++) begin
			@(negedge dspif);
			locked = !acq_we && (acq_addr == acq_last);
		end
		if (!locked) begin
			errors++;
			$display("timeout: acquisition address never locked at the last address");
		end
	endtask

	initial begin
		int n;
		int gap;
		int lows;
		logic [dsp_pkg::acq_addr_width-1:0] first_addr;
		dspif = 1'b0;
		rst_n = 1'b0;
		start = 1'b0;
		cmd_valid = 1'b0;
		cmd_env_word = '0;
		cmd_amp = '0;
		cmd_freq = '0;
		cmd_phase = '0;
		cmd_cfg = '0;
		adc = '0;
		errors = 0;
		checking = 1'b0;
		seed = 32'h8f0f82fa;
		repeat (8) @(posedge dspif);
		#1;
		rst_n = 1'b1;
		checking = 1'b1;
		repeat (3) next_cycle();
		@(negedge dspif);
		check_value("cmd_ready", cmd_ready, 0);
		check_value("acq_we", acq_we, 0);
		check_value("qdrv_stb", qdrv_stb, 0);
		check_value("rdrv_amp", rdrv_amp, 0);
		check_value("rdlo_env_length", rdlo_env_length, 0);
		next_cycle();
		pulse_start();
		wait_ready(lows);
		check_value("flush_cycles", lows, dsp_pkg::flush_cycles);
		next_cycle();
		wait_write(first_addr);
		check_value("acq_addr", first_addr, 0);
		next_cycle();
		for (n = 0; n < 300; n++) begin // random cfg also hits select 3.
			send_cmd(4'(next_rand()));
			gap = int'(next_rand() % 4);
			repeat (gap) next_cycle();
		end
		send_cmd(4'h0); // back to back, one per element.
		send_cmd(4'h5);
		send_cmd(4'hA);
		send_cmd(4'h3);
		send_cmd(4'hC);
		repeat (4) next_cycle();
		wait_lock();
		repeat (5) next_cycle();
		@(negedge dspif);
		check_value("acq_addr", acq_addr, acq_last);
		check_value("acq_we", acq_we, 0);
		next_cycle();
		send_cmd(4'h5);
		repeat (3) next_cycle();
		pulse_start();
		wait_ready(lows);
		check_value("flush_cycles", lows, dsp_pkg::flush_cycles);
		check_value("rdrv_amp", rdrv_amp, 0);
		check_value("rdrv_env_start", rdrv_env_start, 0);
		next_cycle();
		wait_write(first_addr);
		check_value("acq_addr", first_addr, 0);
		next_cycle();
		for (n = 0; n < 20; n++) begin
			send_cmd(4'(next_rand()));
		end
		repeat (10) next_cycle();
		checking = 1'b0;
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire
